//--- hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Integer data path width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Wishbone instruction bus address width
`define BUS_ADDR_W 32

`endif

//--- hw/rvIsaPkg.sv
package rvIsaPkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } majorOpcode;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    // Stores and branches share the split immediate layout
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sbFormat;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormat;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10to1;
        logic        imm11;
        logic [7:0]  imm19to12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } jFormat;

    typedef union packed {
        rFormat  r;
        iFormat  i;
        sbFormat sb;
        uFormat  u;
        jFormat  j;
    } instrWord;

endpackage

//--- hw/corePkg.sv
`include "core_config.svh"

package corePkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } aluOp;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branchKind;

    // Branch compares use opA/opB as rs1/rs2
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] opA;
        logic [`XLEN-1:0] opB;
        logic [`XLEN-1:0] imm;
        aluOp             aluOp;
        branchKind        branchKind;
        regIdx            rd;
        logic             writesRd;
        logic             illegal;
    } microOp;

endpackage

//--- hw/stageIf.sv
`timescale 1ns/1ps
`include "core_config.svh"

interface decodeExecIf import corePkg::*; ();
    logic   valid;
    microOp uop;

    modport producer (output valid, output uop);
    modport consumer (input valid, input uop);
endinterface

interface execResultIf import corePkg::*; ();
    logic             valid;
    logic [`XLEN-1:0] pc;
    regIdx            rd;
    logic             writeEn;
    logic [`XLEN-1:0] value;
    logic [`XLEN-1:0] nextPc;

    modport producer (output valid, output pc, output rd, output writeEn,
                      output value, output nextPc);
    modport consumer (input valid, input pc, input rd, input writeEn,
                      input value, input nextPc);
endinterface

// Combinational register file read
interface regReadIf import corePkg::*; ();
    regIdx            rs1;
    regIdx            rs2;
    logic [`XLEN-1:0] data1;
    logic [`XLEN-1:0] data2;

    modport reader (output rs1, output rs2, input data1, input data2);
    modport file (input rs1, input rs2, output data1, output data2);
endinterface

//--- hw/fetchUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module fetchUnit #(
    parameter logic [`XLEN-1:0] resetPc = `RESET_PC
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic [`BUS_ADDR_W-1:0] wbAdr,
    input  logic [`XLEN-1:0]       wbDatIn,
    input  logic                   wbAck,
    input  logic                   retireValid,
    input  logic [`XLEN-1:0]       nextPc,
    output logic                   instrValid,
    output logic [31:0]            instr,
    output logic [`XLEN-1:0]       instrPc
);

    typedef enum logic {
        sIdle,
        sReq
    } fetchState;

    fetchState        state;
    logic [`XLEN-1:0] pc;
    logic             firstFetch;

    assign wbCyc   = (state == sReq);
    assign wbStb   = (state == sReq);
    assign wbAdr   = pc[`BUS_ADDR_W-1:0];
    assign instrPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= sIdle;
            firstFetch <= 1'b1;
            instrValid <= 1'b0;
            pc         <= resetPc;
        end else begin
            instrValid <= 1'b0;
            case (state)
                sIdle: begin
                    // Next request waits for the previous instruction to retire
                    if (firstFetch || retireValid) begin
                        state      <= sReq;
                        firstFetch <= 1'b0;
                    end
                end
                sReq: begin
                    if (wbAck) begin
                        state      <= sIdle;
                        instrValid <= 1'b1;
                    end
                end
                default: state <= sIdle;
            endcase
            if (retireValid) begin
                pc <= nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == sReq && wbAck) begin
            instr <= wbDatIn[31:0];
        end
    end

    assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc);

    // Classic cycle holds address until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr));

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps
`include "core_config.svh"

module instrDecoder import rvIsaPkg::*, corePkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              instrValid,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  instrPc,
    regReadIf.reader          regRead,
    decodeExecIf.producer     toExec
);

    instrWord word;
    microOp   nextUop;

    function automatic aluOp selectAlu(input logic [2:0] funct3, input logic alt,
                                       input logic isReg);
        aluOp op;
        case (funct3)
            3'b000:  op = (isReg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign word = instr;

    assign regRead.rs1 = word.r.rs1;
    assign regRead.rs2 = word.r.rs2;

    always_comb begin
        logic usePcA;
        logic useImmB;

        usePcA              = 1'b0;
        useImmB             = 1'b0;
        nextUop.pc          = instrPc;
        nextUop.imm         = '0;
        nextUop.aluOp       = ALU_ADD;
        nextUop.branchKind  = BR_NONE;
        nextUop.rd          = word.r.rd;
        nextUop.writesRd    = 1'b0;
        nextUop.illegal     = 1'b0;

        case (word.r.opcode)
            OPC_OP: begin
                nextUop.aluOp    = selectAlu(word.r.funct3, word.r.funct7[5], 1'b1);
                nextUop.writesRd = 1'b1;
            end
            OPC_OP_IMM: begin
                nextUop.imm      = {{20{word.i.imm[11]}}, word.i.imm};
                nextUop.aluOp    = selectAlu(word.i.funct3, word.r.funct7[5], 1'b0);
                nextUop.writesRd = 1'b1;
                useImmB          = 1'b1;
            end
            OPC_LUI: begin
                nextUop.imm      = {word.u.imm, 12'b0};
                nextUop.aluOp    = ALU_PASS_B;
                nextUop.writesRd = 1'b1;
                useImmB          = 1'b1;
            end
            OPC_AUIPC: begin
                nextUop.imm      = {word.u.imm, 12'b0};
                nextUop.writesRd = 1'b1;
                usePcA           = 1'b1;
                useImmB          = 1'b1;
            end
            OPC_BRANCH: begin
                nextUop.imm = {{20{word.sb.immHi[6]}}, word.sb.immLo[0],
                               word.sb.immHi[5:0], word.sb.immLo[4:1], 1'b0};
                case (word.sb.funct3)
                    3'b000:  nextUop.branchKind = BR_BEQ;
                    3'b001:  nextUop.branchKind = BR_BNE;
                    3'b100:  nextUop.branchKind = BR_BLT;
                    3'b101:  nextUop.branchKind = BR_BGE;
                    3'b110:  nextUop.branchKind = BR_BLTU;
                    3'b111:  nextUop.branchKind = BR_BGEU;
                    default: nextUop.illegal    = 1'b1;
                endcase
            end
            OPC_JAL: begin
                nextUop.imm = {{12{word.j.imm20}}, word.j.imm19to12, word.j.imm11,
                               word.j.imm10to1, 1'b0};
                nextUop.branchKind = BR_JAL;
                nextUop.writesRd   = 1'b1;
                usePcA             = 1'b1;
                useImmB            = 1'b1;
            end
            OPC_JALR: begin
                nextUop.imm        = {{20{word.i.imm[11]}}, word.i.imm};
                nextUop.branchKind = BR_JALR;
                nextUop.writesRd   = 1'b1;
                useImmB            = 1'b1;
            end
            default: nextUop.illegal = 1'b1;
        endcase

        nextUop.opA = usePcA ? instrPc : regRead.data1;
        nextUop.opB = useImmB ? nextUop.imm : regRead.data2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            toExec.valid <= 1'b0;
        end else begin
            toExec.valid <= instrValid;
        end
        toExec.uop <= nextUop;
    end

    assert property (@(posedge clk) disable iff (rst)
        toExec.valid && toExec.uop.illegal |-> !toExec.uop.writesRd);

endmodule

//--- hw/intExecute.sv
`timescale 1ns/1ps
`include "core_config.svh"

module intExecute import corePkg::*; (
    input  logic          clk,
    input  logic          rst,
    decodeExecIf.consumer fromDec,
    execResultIf.producer toResult
);

    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] linkPc;
    logic [`XLEN-1:0] target;
    logic             taken;
    logic             isJump;

    always_comb begin
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;

        a = fromDec.uop.opA;
        b = fromDec.uop.opB;
        case (fromDec.uop.aluOp)
            ALU_ADD:    aluResult = a + b;
            ALU_SUB:    aluResult = a - b;
            ALU_SLL:    aluResult = a << b[4:0];
            ALU_SLT:    aluResult = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   aluResult = {{(`XLEN-1){1'b0}}, a < b};
            ALU_XOR:    aluResult = a ^ b;
            ALU_SRL:    aluResult = a >> b[4:0];
            ALU_SRA:    aluResult = $signed(a) >>> b[4:0];
            ALU_OR:     aluResult = a | b;
            ALU_AND:    aluResult = a & b;
            ALU_PASS_B: aluResult = b;
            default:    aluResult = '0;
        endcase

        case (fromDec.uop.branchKind)
            BR_BEQ:  taken = (a == b);
            BR_BNE:  taken = (a != b);
            BR_BLT:  taken = ($signed(a) < $signed(b));
            BR_BGE:  taken = ($signed(a) >= $signed(b));
            BR_BLTU: taken = (a < b);
            BR_BGEU: taken = (a >= b);
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign isJump = (fromDec.uop.branchKind == BR_JAL) || (fromDec.uop.branchKind == BR_JALR);
    assign linkPc = fromDec.uop.pc + `XLEN'd4;

    // JALR adds to the register base, everything else is pc relative
    assign target = (fromDec.uop.branchKind == BR_JALR)
                  ? ((fromDec.uop.opA + fromDec.uop.imm) & ~`XLEN'd1)
                  : (fromDec.uop.pc + fromDec.uop.imm);

    always_ff @(posedge clk) begin
        if (rst) begin
            toResult.valid <= 1'b0;
        end else begin
            toResult.valid <= fromDec.valid;
        end
        toResult.pc      <= fromDec.uop.pc;
        toResult.rd      <= fromDec.uop.rd;
        toResult.writeEn <= fromDec.uop.writesRd;
        toResult.value   <= isJump ? linkPc : aluResult;
        toResult.nextPc  <= taken ? target : linkPc;
    end

endmodule

//--- hw/resultStage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module resultStage import corePkg::*; (
    input  logic             clk,
    input  logic             rst,
    execResultIf.consumer    fromExec,
    regReadIf.file           regFile,
    output logic             retireValid,
    output logic [`XLEN-1:0] retirePc,
    output regIdx            retireRd,
    output logic             retireWe,
    output logic [`XLEN-1:0] retireData,
    output logic [`XLEN-1:0] nextPc
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];
    logic             doWrite;

    assign doWrite = fromExec.valid && fromExec.writeEn && (fromExec.rd != '0);

    assign regFile.data1 = (regFile.rs1 == '0) ? '0 : regs[regFile.rs1];
    assign regFile.data2 = (regFile.rs2 == '0) ? '0 : regs[regFile.rs2];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            regs[fromExec.rd] <= fromExec.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= fromExec.valid;
        end
        retirePc   <= fromExec.pc;
        retireRd   <= fromExec.rd;
        retireWe   <= fromExec.writeEn && (fromExec.rd != '0);
        retireData <= fromExec.value;
        nextPc     <= fromExec.nextPc;
    end

    // One instruction in flight, so retires never come back to back
    assert property (@(posedge clk) disable iff (rst) retireValid |=> !retireValid);

endmodule

//--- hw/miniCore.sv
`timescale 1ns/1ps
`include "core_config.svh"

module miniCore import corePkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic [`BUS_ADDR_W-1:0] wbAdr,
    input  logic [`XLEN-1:0]       wbDatIn,
    input  logic                   wbAck,
    output logic                   retireValid,
    output logic [`XLEN-1:0]       retirePc,
    output regIdx                  retireRd,
    output logic                   retireWe,
    output logic [`XLEN-1:0]       retireData
);

    logic             instrValid;
    logic [31:0]      instr;
    logic [`XLEN-1:0] instrPc;
    logic [`XLEN-1:0] nextPc;

    decodeExecIf decExec ();
    execResultIf execRes ();
    regReadIf    regRead ();

    fetchUnit #(
        .resetPc(`RESET_PC)
    ) fetch (
        .clk        (clk),
        .rst        (rst),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .wbDatIn    (wbDatIn),
        .wbAck      (wbAck),
        .retireValid(retireValid),
        .nextPc     (nextPc),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc)
    );

    instrDecoder decode (
        .clk       (clk),
        .rst       (rst),
        .instrValid(instrValid),
        .instr     (instr),
        .instrPc   (instrPc),
        .regRead   (regRead.reader),
        .toExec    (decExec.producer)
    );

    intExecute execute (
        .clk     (clk),
        .rst     (rst),
        .fromDec (decExec.consumer),
        .toResult(execRes.producer)
    );

    resultStage result (
        .clk        (clk),
        .rst        (rst),
        .fromExec   (execRes.consumer),
        .regFile    (regRead.file),
        .retireValid(retireValid),
        .retirePc   (retirePc),
        .retireRd   (retireRd),
        .retireWe   (retireWe),
        .retireData (retireData),
        .nextPc     (nextPc)
    );

endmodule

//--- test/coreTb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module coreTb import rvIsaPkg::*; ();

    localparam int numRetires = 300;

    typedef struct packed {
        logic [31:0] nextPc;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } expectedRetire;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   wbCyc;
    logic                   wbStb;
    logic [`BUS_ADDR_W-1:0] wbAdr;
    logic [`XLEN-1:0]       wbDatIn;
    logic                   wbAck;
    logic                   retireValid;
    logic [`XLEN-1:0]       retirePc;
    logic [4:0]             retireRd;
    logic                   retireWe;
    logic [`XLEN-1:0]       retireData;

    logic [31:0] mem [64];
    logic [31:0] shadow [32];
    logic [31:0] lfsr;
    logic [31:0] expPc;
    logic [31:0] lastFetch;
    int          fetchCount;
    int          retireCount;
    int          checkCount;
    int          errorCount;

    miniCore dut (
        .clk        (clk),
        .rst        (rst),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .wbDatIn    (wbDatIn),
        .wbAck      (wbAck),
        .retireValid(retireValid),
        .retirePc   (retirePc),
        .retireRd   (retireRd),
        .retireWe   (retireWe),
        .retireData (retireData)
    );

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] encR(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        instrWord w;
        w.r.funct7 = {1'b0, alt, 5'b0};
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] opc, input logic [11:0] imm,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1);
        instrWord w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [2:0] f3,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
        instrWord w;
        w.sb.immHi  = {off[12], off[10:5]};
        w.sb.rs2    = rs2;
        w.sb.rs1    = rs1;
        w.sb.funct3 = f3;
        w.sb.immLo  = {off[4:1], off[11]};
        w.sb.opcode = OPC_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] encU(input logic [6:0] opc, input logic [19:0] imm,
                                         input logic [4:0] rd);
        instrWord w;
        w.u.imm    = imm;
        w.u.rd     = rd;
        w.u.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        instrWord w;
        w.j.imm20     = off[20];
        w.j.imm10to1  = off[10:1];
        w.j.imm11     = off[11];
        w.j.imm19to12 = off[19:12];
        w.j.rd        = rd;
        w.j.opcode    = OPC_JAL;
        return w;
    endfunction

    // Words 0 to 30 give every register a known value before the random mix
    task automatic fillProgram();
        int          idx;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [5:0]  wordOff;
        logic [31:0] offs;
        for (idx = 0; idx < 31; idx++) begin
            if (idx % 3 == 0) begin
                mem[idx] = encU(OPC_LUI, takeBits(20), 5'(idx + 1));
            end else begin
                mem[idx] = encI(OPC_OP_IMM, takeBits(12), 3'b000, 5'(idx + 1), 5'd0);
            end
        end
        idx = 31;
        while (idx < 64) begin
            kind    = takeBits(4);
            rd      = takeBits(5);
            rs1     = takeBits(5);
            rs2     = takeBits(5);
            f3      = takeBits(3);
            alt     = takeBits(1);
            imm     = takeBits(12);
            wordOff = takeBits(6);
            if (wordOff == 0) begin
                wordOff = 6'd1;
            end
            offs = {{24{wordOff[5]}}, wordOff, 2'b00};
            // Shift immediates carry only the shamt and the arithmetic bit
            if (f3 == 3'b001) begin
                imm = {7'b0, imm[4:0]};
            end else if (f3 == 3'b101) begin
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            end
            case (kind)
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    mem[idx] = encR(f3, alt && (f3 == 3'b000 || f3 == 3'b101), rd, rs1, rs2);
                end
                4'd4, 4'd5, 4'd6, 4'd7: mem[idx] = encI(OPC_OP_IMM, imm, f3, rd, rs1);
                4'd8:  mem[idx] = encU(OPC_LUI, {imm, wordOff, 2'b01}, rd);
                4'd9:  mem[idx] = encU(OPC_AUIPC, {wordOff, imm, 2'b10}, rd);
                4'd10, 4'd11: begin
                    if (f3 == 3'b010 || f3 == 3'b011) begin
                        f3 = f3 ^ 3'b100;
                    end
                    mem[idx] = encB(offs[12:0], f3, rs1, rs2);
                end
                4'd12: mem[idx] = encJ(offs[20:0], rd);
                4'd13: begin
                    mem[idx] = encI(OPC_OP_IMM, {4'b0, wordOff, 2'b00}, 3'b000, rs1, 5'd0);
                    if (idx < 63) begin
                        idx++;
                        mem[idx] = encI(OPC_JALR, 12'd0, 3'b000, rd, rs1);
                    end
                end
                4'd14: mem[idx] = {25'(takeBits(25)), 7'b0001011};
                default: mem[idx] = encI(OPC_OP_IMM, imm, 3'b000, 5'd0, rs1);
            endcase
            idx++;
        end
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic isSub, input logic [31:0] a,
                                           input logic [31:0] b);
        case (f3)
            3'd0: return isSub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Expected retire of word w at pc, from the RV32I encoding rules
    function automatic expectedRetire refStep(input logic [31:0] pc, input logic [31:0] w);
        expectedRetire r;
        logic [31:0]   a;
        logic [31:0]   b;
        logic [31:0]   immI;
        logic [31:0]   immB;
        logic [31:0]   immU;
        logic [31:0]   immJ;
        logic          taken;
        a     = shadow[w[19:15]];
        b     = shadow[w[24:20]];
        immI  = {{20{w[31]}}, w[31:20]};
        immB  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immU  = {w[31:12], 12'b0};
        immJ  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        taken = 1'b0;
        r.nextPc = pc + 32'd4;
        r.we     = 1'b0;
        r.rd     = w[11:7];
        r.data   = '0;
        case (w[6:0])
            7'b0110011: begin
                r.data = aluRef(w[14:12], w[30], w[30], a, b);
                r.we   = 1'b1;
            end
            7'b0010011: begin
                r.data = aluRef(w[14:12], w[30], 1'b0, a, immI);
                r.we   = 1'b1;
            end
            7'b0110111: begin
                r.data = immU;
                r.we   = 1'b1;
            end
            7'b0010111: begin
                r.data = pc + immU;
                r.we   = 1'b1;
            end
            7'b1100011: begin
                case (w[14:12])
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    r.nextPc = pc + immB;
                end
            end
            7'b1101111: begin
                r.data   = pc + 32'd4;
                r.we     = 1'b1;
                r.nextPc = pc + immJ;
            end
            7'b1100111: begin
                r.data   = pc + 32'd4;
                r.we     = 1'b1;
                r.nextPc = (a + immI) & ~32'd1;
            end
            default: r.we = 1'b0;
        endcase
        r.we = r.we && (r.rd != 5'd0);
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait states
    initial begin
        int waitLeft;
        waitLeft = -1;
        forever begin
            @(posedge clk);
            #1;
            if (wbAck) begin
                wbAck = 1'b0;
            end else if (!rst && wbCyc && wbStb) begin
                if (waitLeft < 0) begin
                    waitLeft = int'(takeBits(2));
                end
                if (waitLeft == 0) begin
                    wbDatIn  = mem[wbAdr[7:2]];
                    wbAck    = 1'b1;
                    waitLeft = -1;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    always @(negedge clk) begin
        expectedRetire exp;
        if (rst) begin
            checkCount++;
            assert (!wbCyc && !wbStb && !retireValid) else begin
                errorCount++;
                $display("Bus request or retire pulse seen while reset is held");
            end
        end else begin
            if (wbCyc && wbStb && wbAck) begin
                checkValue("fetch address", expPc, wbAdr);
                checkCount++;
                assert (fetchCount == retireCount) else begin
                    errorCount++;
                    $display("A fetch started before the previous instruction retired");
                end
                lastFetch = wbAdr;
                fetchCount++;
            end
            if (retireValid) begin
                exp = refStep(expPc, mem[expPc[7:2]]);
                checkValue("retire pc", expPc, retirePc);
                checkValue("retire pc vs last fetch", lastFetch, retirePc);
                checkValue("fetches per retire", retireCount + 1, fetchCount);
                checkValue("write enable", exp.we, retireWe);
                if (exp.we) begin
                    checkValue("destination register", exp.rd, retireRd);
                    checkValue("result data", exp.data, retireData);
                    shadow[exp.rd] = exp.data;
                end
                expPc = exp.nextPc;
                retireCount++;
            end
        end
    end

    initial begin
        #(numRetires * 10 * 10 * 2);
        $display("Watchdog expired: retire stalled after %0d of %0d instructions",
                 retireCount, numRetires);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        wbAck       = 1'b0;
        wbDatIn     = '0;
        expPc       = `RESET_PC;
        lastFetch   = '0;
        fetchCount  = 0;
        retireCount = 0;
        checkCount  = 0;
        errorCount  = 0;
        lfsr        = 32'd86223;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        fillProgram();
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        wait (retireCount == numRetires);
        $display("Retired %0d instructions, %0d checks, %0d errors",
                 retireCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+hw
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/stageIf.sv
hw/fetchUnit.sv
hw/instrDecoder.sv
hw/intExecute.sv
hw/resultStage.sv
hw/miniCore.sv
test/coreTb.sv
